// ==== sources.f ====
+incdir+logic
+incdir+sim
logic/fp64Pkg.sv
logic/fpRoundCfg.sv
logic/fpNormalize64.sv
logic/fpRound64.sv
logic/fpRoundTop.sv
sim/fpRoundTb.sv

// ==== sim/fpRoundModel.svh ====
// reference model of the back end: normalize and round in integer arithmetic, plus the LFSR
`ifndef FP_ROUND_MODEL_SVH
`define FP_ROUND_MODEL_SVH

// predicted result word and its flag contribution
typedef struct packed {
	Fp64    data;
	FpFlags fl;
} ModelOut;

// 32-bit Fibonacci LFSR, taps 32 22 2 1, new bit enters at the lsb
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// ------------------------------
// normalize, then round to 53 bits
// ------------------------------
function automatic ModelOut predict(input FpWide w, input RoundMode m);
	ModelOut     r;
	int          lz;
	int          e;
	int          shift;
	logic [63:0] a;
	logic [53:0] keep;    // hidden bit and fraction, spare msb for the carry
	logic [10:0] rem;     // everything below the lsb
	logic        lost;
	logic        up;
	r           = '0;
	r.data.sign = w.sign;
	if (w.mag == '0) begin
		return r;         // signed zero, exact
	end
	lz = 0;
	while (!w.mag[63 - lz]) begin
		lz++;
	end
	e = int'(w.exp) - lz;
	if (e >= 1) begin
		shift = lz;
	end else begin
		shift = int'(w.exp) - 1;   // stop at 2^-1022
		e     = 0;
	end
	if (e >= `FP_EXP_MAX) begin
		r.data.exp  = '1;          // saturated before rounding
		r.fl.overflow = 1'b1;
		return r;
	end
	a    = w.mag << shift;
	keep = {1'b0, a[63:11]};
	rem  = a[10:0];
	lost = (rem != '0);
	// half an ulp is 11'h400
	case (m)
		RTZ:     up = 1'b0;
		RUP:     up = lost && !w.sign;
		RDN:     up = lost && w.sign;
		RMM:     up = (rem >= 11'h400);
		default: up = (rem > 11'h400) || (rem == 11'h400 && keep[0]);
	endcase
	keep = keep + 54'(up);
	if (keep[53]) begin
		keep = keep >> 1;         // 2.0 becomes 1.0 at the next exponent
		e++;
	end else if (e == 0 && keep[52]) begin
		e = 1;                    // subnormal grew into the smallest normal
	end
	r.fl.inexact = lost;
	if (e >= `FP_EXP_MAX) begin
		r.data.exp    = '1;
		r.fl.overflow = 1'b1;
	end else begin
		r.data.exp = 11'(e);
		r.data.sig = keep[51:0];
	end
	return r;
endfunction

`endif

// ==== sim/fpRoundTb.sv ====
// testbench for the normalize-and-round back end, model-checked results, flags and latency
`timescale 1ns/1ns
`default_nettype none

`include "fp64_consts.svh"

module fpRoundTb
	import fp64Pkg::*;
();

	`include "fpRoundModel.svh"

	typedef struct packed {
		ModelOut     res;
		logic [31:0] stamp;   // ce-edge count when the input was taken
	} Pending;

	logic     clk;
	logic     rstN;
	logic     ce;
	logic     inValid;
	FpWide    inData;
	logic     cfgWe;
	RoundMode cfgMode;
	logic     flagClr;
	logic     outValid;
	Fp64      outData;
	FpFlags   flags;
	RoundMode mode;

	Pending      expQ[$];     // scoreboard, oldest first
	FpFlags      expFlags;    // OR of predictions since the last clear
	RoundMode    curMode;
	logic [31:0] ceCount;
	logic [31:0] lfsr;
	string       testName;

	fpRoundTop fpRoundTop_i (
		.clk      (clk),
		.rstN     (rstN),
		.ce       (ce),
		.inValid  (inValid),
		.inData   (inData),
		.cfgWe    (cfgWe),
		.cfgMode  (cfgMode),
		.flagClr  (flagClr),
		.outValid (outValid),
		.outData  (outData),
		.flags    (flags),
		.mode     (mode)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;    // 8 ns
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic failStop(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic failValue(input string name, input logic [63:0] expv, input logic [63:0] actv);
		failStop($sformatf("ERROR %s: expected %h, actual %h", name, expv, actv));
	endtask

	function automatic logic [63:0] randBits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			r    = {r[62:0], lfsr[0]};   // one step per bit
		end
		return r;
	endfunction

	function automatic FpWide randWide();
		FpWide      w;
		logic [1:0] cls;
		w.sign = 1'(randBits(1));
		cls    = 2'(randBits(2));
		w.mag  = randBits(64) >> randBits(6);   // spread of leading zeros
		case (cls)
			2'd0:    w.exp = 12'(1 + randBits(6));      // subnormal region
			2'd1:    w.exp = 12'(960 + randBits(7));
			2'd2:    w.exp = 12'(1980 + randBits(7));   // near and past infinity
			default: w.exp = 12'(randBits(12)) | 12'd1; // never zero
		endcase
		return w;
	endfunction

	// holds the input through edges with ce low until one ce edge takes it
	task automatic send(input FpWide w, input logic dropCe);
		logic ceNow;
		int   tries;
		tries = 0;
		do begin
			@(posedge clk);
			ceNow    = !dropCe || tries == 3 || randBits(2) != '0;
			inValid <= 1'b1;
			inData  <= w;
			ce      <= ceNow;
			tries++;
		end while (!ceNow);
	endtask

	task automatic drain();
		int t;
		t = 0;
		@(posedge clk);
		inValid <= 1'b0;
		ce      <= 1'b1;
		@(posedge clk);           // last sample is now on the queue
		while (expQ.size() != 0 && t < 40) begin
			@(posedge clk);
			t++;
		end
		assert (expQ.size() == 0) else failStop({"timeout in ", testName, ", results missing"});
		repeat (2) @(posedge clk);  // flags follow outValid by a clock
		assert (flags == expFlags) else failValue({testName, " flags"}, expFlags, flags);
		assert (mode == curMode) else failValue({testName, " mode"}, curMode, mode);
	endtask

	task automatic setMode(input RoundMode m);
		@(posedge clk);
		cfgWe   <= 1'b1;
		cfgMode <= m;
		curMode  = m;
		@(posedge clk);
		cfgWe   <= 1'b0;
	endtask

	task automatic clearFlags();
		@(posedge clk);
		flagClr <= 1'b1;
		@(posedge clk);
		flagClr <= 1'b0;
		expFlags = '0;
	endtask

	// ------------------------------
	// scoreboard
	// ------------------------------
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ceCount <= '0;
		end else if (ce) begin
			ceCount <= ceCount + 1;
		end
	end

	always @(posedge clk) begin
		if (rstN && ce && inValid) begin
			expQ.push_back({predict(inData, curMode), ceCount});
		end
	end

	always @(posedge clk) begin : compare
		Pending p;
		if (rstN && outValid) begin
			assert (expQ.size() != 0) else failStop("outValid seen with no input pending");
			p = expQ.pop_front();
			assert (ceCount == p.stamp + 5)
				else failValue({testName, " latency"}, p.stamp + 5, ceCount);
			assert (outData == p.res.data) else failValue(testName, p.res.data, outData);
			expFlags = expFlags | p.res.fl;
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : stimulus
		lfsr     = 32'h428d_a448;
		rstN     = 1'b0;
		ce       = 1'b0;
		inValid  = 1'b0;
		inData   = '0;
		cfgWe    = 1'b0;
		cfgMode  = RNE;
		flagClr  = 1'b0;
		curMode  = RNE;
		expFlags = '0;
		testName = "reset";
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		@(posedge clk);
		assert (!outValid && flags == '0 && mode == RNE) else failStop("wrong state after reset");

		// tie, odd tie, above and below a tie, sticky only
		testName = "ties";
		for (int md = 0; md < 5; md++) begin
			setMode(RoundMode'(md));
			for (int s = 0; s < 2; s++) begin
				send({s[0], 12'd1023, 64'h8000_0000_0000_0400}, 1'b0);
				send({s[0], 12'd1023, 64'h8000_0000_0000_0C00}, 1'b0);
				send({s[0], 12'd1023, 64'h8000_0000_0000_0401}, 1'b0);
				send({s[0], 12'd1023, 64'h8000_0000_0000_03FF}, 1'b0);
				send({s[0], 12'd1023, 64'h8000_0000_0000_0001}, 1'b0);
			end
			drain();
		end

		testName = "carry";
		setMode(RNE);
		send({1'b0, 12'd1023, 64'hFFFF_FFFF_FFFF_FC00}, 1'b0);  // all ones, odd tie
		send({1'b1, 12'd2046, 64'hFFFF_FFFF_FFFF_FC00}, 1'b0);  // carries into infinity
		send({1'b0, 12'd2047, 64'hFFFF_FFFF_FFFF_FFFF}, 1'b0);  // saturated
		send({1'b1, 12'd3000, 64'h0000_0000_0000_0001}, 1'b0);
		drain();
		setMode(RUP);
		send({1'b0, 12'd2047, 64'h8000_0000_0000_0001}, 1'b0);  // infinity is never incremented
		drain();

		testName = "subnormal";
		send({1'b0, 12'd1, 64'h4000_0000_0000_0000}, 1'b0);
		send({1'b0, 12'd1, 64'h7FFF_FFFF_FFFF_FFFF}, 1'b0);    // up to the smallest normal
		send({1'b1, 12'd5, 64'h0000_0000_0000_0123}, 1'b0);
		send({1'b0, 12'd500, 64'h0}, 1'b0);                    // zero magnitude
		drain();

		testName = "flags";
		setMode(RNE);
		clearFlags();
		send({1'b0, 12'd1023, 64'h8000_0000_0000_0000}, 1'b0);  // exact, nothing set
		drain();
		send({1'b0, 12'd1023, 64'h8000_0000_0000_0001}, 1'b0);
		send({1'b0, 12'd2046, 64'hFFFF_FFFF_FFFF_FFFF}, 1'b0);
		drain();
		send({1'b0, 12'd1023, 64'hC000_0000_0000_0000}, 1'b0);  // both stay set
		drain();
		clearFlags();
		drain();

		// back-to-back runs with ce dropped at random, codes 5 to 7 too
		testName = "random";
		for (int n = 0; n < 300; n++) begin
			if (n % 25 == 0) begin
				drain();
				setMode(RoundMode'(randBits(3)));
			end
			send(randWide(), 1'(randBits(1)));
		end
		drain();

		if (expQ.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			failStop("results left pending at the end of the run");
		end
	end

endmodule

`default_nettype wire

// ==== logic/fpRoundTop.sv ====
// normalize-and-round back end: wide result in, packed binary64 and flags out
`timescale 1ns/1ns
`default_nettype none

`include "fp64_consts.svh"

module fpRoundTop
	import fp64Pkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     ce,
	input  logic     inValid,
	input  FpWide    inData,
	input  logic     cfgWe,
	input  RoundMode cfgMode,
	input  logic     flagClr,
	output logic     outValid,
	output Fp64      outData,
	output FpFlags   flags,
	output RoundMode mode       // current rounding mode
);

	// ------------------------------
	// internal paths
	// ------------------------------
	logic   normValid;
	Fp64N   normData;           // FP64N between the two pipes
	FpFlags resFlags;

	// 2 ce-cycles
	fpNormalize64 fpNormalize64_i (
		.clk       (clk),
		.rstN      (rstN),
		.ce        (ce),
		.inValid   (inValid),
		.inData    (inData),
		.normValid (normValid),
		.normData  (normData)
	);

	// 3 ce-cycles
	fpRound64 fpRound64_i (
		.clk       (clk),
		.rstN      (rstN),
		.ce        (ce),
		.normValid (normValid),
		.normData  (normData),
		.mode      (mode),
		.outValid  (outValid),
		.outData   (outData),
		.resFlags  (resFlags)
	);

	fpRoundCfg fpRoundCfg_i (
		.clk      (clk),
		.rstN     (rstN),
		.cfgWe    (cfgWe),
		.cfgMode  (cfgMode),
		.flagClr  (flagClr),
		.outValid (outValid),
		.resFlags (resFlags),
		.mode     (mode),
		.flags    (flags)
	);

endmodule

`default_nettype wire

// ==== logic/fpRound64.sv ====
// three-stage rounder from FP64N to binary64 with inexact and overflow detection
`timescale 1ns/1ns
`default_nettype none

`include "fp64_consts.svh"

module fpRound64
	import fp64Pkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     ce,
	input  logic     normValid,
	input  Fp64N     normData,
	input  RoundMode mode,       // sampled by clock 1 only
	output logic     outValid,
	output Fp64      outData,
	output FpFlags   resFlags    // qualified by outValid
);

	localparam int ExpW = `FP_EXP_W;
	localparam int SigW = `FP_FRAC_W + 1;  // hidden bit plus fraction

	// ------------------------------
	// clock 1: round decision
	// ------------------------------
	logic lsb;
	logic guardB;
	logic roundB;
	logic stickyB;
	logic lostBits;
	logic xInf;
	logic rndNxt;

	assign lsb      = normData.mant[`FP_NMANT_W-SigW];
	assign guardB   = normData.mant[2];
	assign roundB   = normData.mant[1];
	assign stickyB  = normData.mant[0];
	assign lostBits = guardB | roundB | stickyB;
	assign xInf     = &normData.exp;  // saturated by the normalizer

	always_comb begin : roundDecide
		rndNxt = 1'b0;
		if (!xInf) begin  // infinities pass untouched
			case (mode)
				RTZ:     rndNxt = 1'b0;                     // truncate
				RUP:     rndNxt = lostBits & ~normData.sign;
				RDN:     rndNxt = lostBits & normData.sign;
				RMM:     rndNxt = guardB;                   // ties away
				default: rndNxt = guardB & (roundB | stickyB | lsb);  // RNE, codes 5..7
			endcase
		end
	end

	logic            v1;
	logic            sign1;
	logic [ExpW-1:0] exp1;
	logic [SigW-1:0] sig1;
	logic            rnd1;
	logic            inexact1;

	always_ff @(posedge clk) begin
		if (ce) begin
			sign1    <= normData.sign;
			exp1     <= normData.exp;
			sig1     <= normData.mant[`FP_NMANT_W-1 -: SigW];  // drop GRS
			rnd1     <= rndNxt;
			inexact1 <= lostBits;
		end
	end

	// ------------------------------
	// clock 2: add at lsb
	// ------------------------------
	logic            v2;
	logic            sign2;
	logic [ExpW-1:0] exp2;
	logic [SigW:0]   sum2;      // extra msb takes the carry
	logic            carry2;
	logic            dn2;       // subnormal input
	logic            inexact2;
	logic [SigW:0]   sumNxt;

	assign sumNxt = {1'b0, sig1} + {{SigW{1'b0}}, rnd1};

	always_ff @(posedge clk) begin
		if (ce) begin
			sign2    <= sign1;
			exp2     <= exp1;
			sum2     <= sumNxt;
			carry2   <= sumNxt[SigW];   // 1.111.. + 1 -> 10.000..
			dn2      <= (exp1 == '0);
			inexact2 <= inexact1;
		end
	end

	// ------------------------------
	// clock 3: fraction select
	// ------------------------------
	logic                  incExp;
	logic [ExpW-1:0]       expRes;
	logic [`FP_FRAC_W-1:0] fracRes;

	always_comb begin : fracSelect
		// carry, or a subnormal that grew its hidden bit
		incExp = carry2 | (dn2 & sum2[SigW-1]);
		expRes = exp2 + ExpW'(incExp);
		if (&expRes) begin
			fracRes = '0;                         // became or stayed infinite
		end else if (carry2) begin
			fracRes = sum2[SigW-1:1];             // renormalize one place
		end else begin
			fracRes = sum2[`FP_FRAC_W-1:0];       // hide msb
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			outData.sign      <= sign2;
			outData.exp       <= expRes;
			outData.sig       <= fracRes;
			resFlags.inexact  <= inexact2;
			resFlags.overflow <= &expRes;         // rounded up to inf or came saturated
		end
	end

	// valid delay line, outValid pulses one clock per item even with ce low after
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			v1       <= 1'b0;
			v2       <= 1'b0;
			outValid <= 1'b0;
		end else begin
			if (ce) begin
				v1 <= normValid;
				v2 <= v1;
			end
			outValid <= ce & v2;
		end
	end

	validKnown: assert property (
		@(posedge clk) disable iff (!rstN)
		!$isunknown(outValid)
	) else $error("outValid unknown after reset");

endmodule

`default_nettype wire

// ==== logic/fpNormalize64.sv ====
// two-stage leading-zero normalizer from a wide magnitude to the FP64N intermediate
`timescale 1ns/1ns
`default_nettype none

`include "fp64_consts.svh"

module fpNormalize64
	import fp64Pkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  logic  ce,         // global advance
	input  logic  inValid,
	input  FpWide inData,
	output logic  normValid,
	output Fp64N  normData
);

	localparam int ShiftW = $clog2(`FP_WIDE_W + 1);  // shift of 0..64
	localparam int WExpW  = `FP_WEXP_W + 1;           // one spare bit for the borrow
	localparam int ExpW   = `FP_EXP_W;
	localparam int KeepW  = `FP_NMANT_W - 1;          // hidden, fraction, guard, round
	localparam int DropW  = `FP_WIDE_W - KeepW;       // bits folded into sticky

	// ------------------------------
	// stage 1: count and pick shift
	// ------------------------------
	logic [ShiftW-1:0]     lzCnt;
	logic [WExpW-1:0]      expDiff;   // exp - lzCnt, msb set on borrow
	logic                  magZero;
	logic                  isNormal;
	logic [ShiftW-1:0]     shiftNxt;
	logic [`FP_WEXP_W-1:0] expNxt;

	// leading zeros, highest set bit wins
	always_comb begin : lzCount
		lzCnt = ShiftW'(`FP_WIDE_W);
		for (int i = 0; i < `FP_WIDE_W; i++) begin
			if (inData.mag[i]) begin
				lzCnt = ShiftW'(`FP_WIDE_W - 1 - i);
			end
		end
	end

	assign magZero  = (inData.mag == '0);
	assign expDiff  = {1'b0, inData.exp} - WExpW'(lzCnt);
	assign isNormal = !expDiff[WExpW-1] && (expDiff != '0);  // exp - lz >= 1

	always_comb begin : shiftPick
		if (magZero) begin
			shiftNxt = '0;                      // nothing to move
			expNxt   = '0;
		end else if (isNormal) begin
			shiftNxt = lzCnt;                   // full normalize
			expNxt   = expDiff[`FP_WEXP_W-1:0];
		end else begin
			// limit shift so the value lands at 2^-1022, subnormal
			shiftNxt = ShiftW'(inData.exp - 1'b1);
			expNxt   = '0;
		end
	end

	logic                  s1Valid;
	logic                  s1Sign;
	logic [`FP_WEXP_W-1:0] s1Exp;
	logic [ShiftW-1:0]     s1Shift;
	logic [`FP_WIDE_W-1:0] s1Mag;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else if (ce) begin
			s1Valid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			s1Sign  <= inData.sign;
			s1Exp   <= expNxt;
			s1Shift <= shiftNxt;
			s1Mag   <= inData.mag;
		end
	end

	// ------------------------------
	// stage 2: shift, sticky, saturate
	// ------------------------------
	logic [`FP_WIDE_W-1:0] shifted;
	logic                  sticky;
	logic                  expSat;

	assign shifted = s1Mag << s1Shift;      // never loses top bits, shift <= lz
	assign sticky  = |shifted[DropW-1:0];
	assign expSat  = (s1Exp >= `FP_EXP_MAX);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			normValid <= 1'b0;
		end else if (ce) begin
			normValid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			normData.sign <= s1Sign;
			if (expSat) begin
				normData.exp  <= ExpW'(`FP_EXP_MAX);  // infinity, zero mantissa
				normData.mant <= '0;
			end else begin
				normData.exp  <= s1Exp[ExpW-1:0];
				normData.mant <= {shifted[`FP_WIDE_W-1 -: KeepW], sticky};
			end
		end
	end

	// producers always deliver a biased exponent of at least one
	inExpNonZero: assert property (
		@(posedge clk) disable iff (!rstN)
		inValid |-> (inData.exp != '0)
	) else $error("input exponent zero with inValid");

endmodule

`default_nettype wire

// ==== logic/fpRoundCfg.sv ====
// rounding-mode register and sticky exception flags beside the rounder
`timescale 1ns/1ns
`default_nettype none

`include "fp64_consts.svh"

module fpRoundCfg
	import fp64Pkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     cfgWe,     // mode write strobe
	input  RoundMode cfgMode,
	input  logic     flagClr,   // clear strobe for the sticky flags
	input  logic     outValid,  // result strobe from the rounder
	input  FpFlags   resFlags,  // per-result flags, only meaningful with outValid
	output RoundMode mode,
	output FpFlags   flags
);

	// ------------------------------
	// mode register
	// ------------------------------
	// new mode shows up one clock after the write
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mode <= RNE;
		end else if (cfgWe) begin
			mode <= cfgMode;
		end
	end

	// ------------------------------
	// sticky flags
	// ------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (flagClr) begin
			flags <= '0;                  // clear wins over a same-cycle set
		end else if (outValid) begin
			flags.inexact  <= flags.inexact  | resFlags.inexact;
			flags.overflow <= flags.overflow | resFlags.overflow;
		end
	end

	// a write and a clear in one cycle mean two masters fight over this block
	cfgExclusive: assert property (
		@(posedge clk) disable iff (!rstN)
		!(cfgWe && flagClr)
	) else $error("cfgWe and flagClr high together");

endmodule

`default_nettype wire

// ==== logic/fp64Pkg.sv ====
// types for the binary64 back end: result word, FP64N intermediate, wide input, modes
`default_nettype none

`include "fp64_consts.svh"

package fp64Pkg;

	// ------------------------------
	// packed binary64 result
	// ------------------------------
	typedef struct packed {
		logic                   sign;
		logic [`FP_EXP_W-1:0]   exp;   // biased, 0 for zero and subnormal
		logic [`FP_FRAC_W-1:0]  sig;   // stored fraction
	} Fp64;

	// intermediate format, rounder input
	typedef struct packed {
		logic                   sign;
		logic [`FP_EXP_W-1:0]   exp;   // all ones means infinite, never rounded
		logic [`FP_NMANT_W-1:0] mant;  // hidden, fraction, guard, round, sticky
	} Fp64N;

	// unnormalized input from a producer unit
	// value is mag / 2^63 * 2^(exp - 1023)
	typedef struct packed {
		logic                   sign;
		logic [`FP_WEXP_W-1:0]  exp;
		logic [`FP_WIDE_W-1:0]  mag;
	} FpWide;

	// rounding modes, codes 5 to 7 act as RNE
	typedef enum logic [2:0] {
		RNE = 3'd0,  // nearest, ties to even
		RTZ = 3'd1,  // toward zero
		RUP = 3'd2,  // toward +inf
		RDN = 3'd3,  // toward -inf
		RMM = 3'd4   // nearest, ties away
	} RoundMode;

	typedef struct packed {
		logic inexact;
		logic overflow;
	} FpFlags;

endpackage

`default_nettype wire

// ==== logic/fp64_consts.svh ====
// binary64 field widths and exponent limits shared by the normalize and round back end
`ifndef FP64_CONSTS_SVH
`define FP64_CONSTS_SVH

// ------------------------------
// binary64 word
// ------------------------------
`define FP_EXP_W    11      // exponent field
`define FP_FRAC_W   52      // stored fraction, hidden bit not included

// ------------------------------
// intermediate FP64N mantissa
// ------------------------------
// hidden bit, 52 fraction bits, then guard, round and sticky
`define FP_NMANT_W  56

// ------------------------------
// unnormalized input
// ------------------------------
`define FP_WIDE_W   64      // magnitude, binary point below the msb
`define FP_WEXP_W   12      // biased exponent, room for overflow past 2047

`define FP_EXP_MAX  2047    // all ones, infinity

`endif
